/* design/raycaster_pkg.sv */
package raycaster_pkg;

    // ----------------------------------------------------------
    // Widths with a meaning
    // ----------------------------------------------------------
    typedef logic [5:0]  voxel_coord_t;
    typedef logic [10:0] screen_coord_t;
    // Unsigned fixed point, FRAC_BITS fraction bits
    typedef logic [15:0] ray_pos_t;
    typedef logic [63:0] voxel_word_t;
    // Concatenation of x, y and z
    typedef logic [17:0] voxel_addr_t;
    typedef logic [7:0]  channel_t;
    typedef logic [31:0] pixel_word_t;
    typedef logic [31:0] pixel_addr_t;
    typedef logic [7:0]  step_count_t;

    // Scene and marching
    localparam int GRID_SIZE       = 64;
    localparam int FRAC_BITS       = 8;
    localparam int MAX_STEPS       = 128;
    localparam int ALPHA_THRESHOLD = 10;

    // ----------------------------------------------------------
    // Voxel record layout
    // ----------------------------------------------------------
    localparam int PROPS_LSB    = 56;
    localparam int EMISSIVE_LSB = 48;
    localparam int ALPHA_LSB    = 40;
    localparam int LIGHT_LSB    = 32;
    localparam int COLOR_LSB    = 8;   // 24 bits, R in the top byte
    localparam int MAT_LSB      = 4;   // 4 bits

    // Material codes
    localparam logic [3:0] MAT_EMISSIVE = 4'd1;
    localparam logic [3:0] MAT_GLASS    = 4'd2;
    localparam logic [3:0] MAT_MIRROR   = 4'd3;
    localparam logic [3:0] MAT_WATER    = 4'd5;

    // Pixel constants
    localparam channel_t    SKY_MATERIAL_ID = 8'd255;
    localparam pixel_word_t UP_NORMAL_WORD  = {8'd0, 8'd0, 8'd127, 8'd0};
    // R, G, B added to the selected voxel
    localparam logic [23:0] SEL_BOOST       = {8'd96, 8'd16, 8'd96};

endpackage

/* design/raycaster_ifs.sv */
`timescale 1ns/1ps

// Screen pixel and its volume column, scanner to marcher
interface ray_if;
    import raycaster_pkg::*;

    logic          req;
    logic          ack;
    screen_coord_t pixel_x;
    screen_coord_t pixel_y;
    voxel_coord_t  map_y;
    voxel_coord_t  map_z;

    modport sender   (output req, pixel_x, pixel_y, map_y, map_z, input ack);
    modport receiver (input req, pixel_x, pixel_y, map_y, map_z, output ack);
endinterface

// March result, marcher to shader
interface hit_if;
    import raycaster_pkg::*;

    logic          req;
    logic          ack;
    screen_coord_t pixel_x;
    screen_coord_t pixel_y;
    logic          hit;
    voxel_word_t   voxel;
    voxel_coord_t  voxel_x;
    voxel_coord_t  voxel_y;
    voxel_coord_t  voxel_z;
    step_count_t   steps;

    modport sender (
        output req, pixel_x, pixel_y, hit, voxel, voxel_x, voxel_y, voxel_z, steps,
        input  ack
    );
    modport receiver (
        input  req, pixel_x, pixel_y, hit, voxel, voxel_x, voxel_y, voxel_z, steps,
        output ack
    );
endinterface

// Shaded pixel, shader to writer
interface pixel_if;
    import raycaster_pkg::*;

    logic          req;
    logic          ack;
    screen_coord_t pixel_x;
    screen_coord_t pixel_y;
    pixel_word_t   word0;
    pixel_word_t   word1;
    pixel_word_t   word2;

    modport sender   (output req, pixel_x, pixel_y, word0, word1, word2, input ack);
    modport receiver (input req, pixel_x, pixel_y, word0, word1, word2, output ack);
endinterface

/* design/pixel_scanner.sv */
`timescale 1ns/1ps

module pixel_scanner #(
    parameter int screen_width  = 480,
    parameter int screen_height = 360
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  frame_done,
    output logic  busy,
    ray_if.sender ray
);
    import raycaster_pkg::*;

    typedef enum logic [1:0] {
        scan_idle,
        scan_issue,
        scan_wait_ack
    } scan_state_t;

    scan_state_t state;
    logic        last_pixel;

    assign last_pixel = (ray.pixel_x == screen_coord_t'(screen_width - 1)) &&
                        (ray.pixel_y == screen_coord_t'(screen_height - 1));

    // Screen to volume column, stable while the counters hold
    assign ray.map_y = voxel_coord_t'((32'(ray.pixel_y) * (GRID_SIZE - 1)) /
                                      (screen_height - 1));
    assign ray.map_z = voxel_coord_t'((32'(ray.pixel_x) * (GRID_SIZE - 1)) /
                                      (screen_width - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= scan_idle;
            busy        <= 1'b0;
            ray.req     <= 1'b0;
            ray.pixel_x <= '0;
            ray.pixel_y <= '0;
        end else begin
            case (state)
                // Also parks here after the last ray until the writer finishes
                scan_idle: begin
                    if (frame_done) begin
                        busy <= 1'b0;
                    end else if (start && !busy) begin
                        busy        <= 1'b1;
                        ray.pixel_x <= '0;
                        ray.pixel_y <= '0;
                        state       <= scan_issue;
                    end
                end
                scan_issue: begin
                    if (!ray.ack) begin
                        ray.req <= 1'b1;
                        state   <= scan_wait_ack;
                    end
                end
                scan_wait_ack: begin
                    if (ray.ack) begin
                        ray.req <= 1'b0;
                        if (last_pixel) begin
                            state <= scan_idle;
                        end else begin
                            state <= scan_issue;
                            if (ray.pixel_x == screen_coord_t'(screen_width - 1)) begin
                                ray.pixel_x <= '0;
                                ray.pixel_y <= ray.pixel_y + 1'b1;
                            end else begin
                                ray.pixel_x <= ray.pixel_x + 1'b1;
                            end
                        end
                    end
                end
                default: state <= scan_idle;
            endcase
        end
    end

endmodule

/* design/ray_marcher.sv */
`timescale 1ns/1ps

module ray_marcher (
    input  logic                       clk,
    input  logic                       rst_n,
    ray_if.receiver                    ray,
    hit_if.sender                      hit,
    output logic                       voxel_req,
    output raycaster_pkg::voxel_addr_t voxel_addr,
    input  logic                       voxel_ack,
    input  raycaster_pkg::voxel_word_t voxel_data
);
    import raycaster_pkg::*;

    typedef enum logic [2:0] {
        march_idle,
        march_request,
        march_release,
        march_test,
        march_report
    } march_state_t;

    localparam ray_pos_t start_pos = ray_pos_t'((GRID_SIZE - 1) << FRAC_BITS);
    localparam ray_pos_t half_step = ray_pos_t'(1 << (FRAC_BITS - 1));

    march_state_t state;
    ray_pos_t     pos;
    voxel_coord_t map_y;
    voxel_coord_t map_z;
    logic         accept;
    logic         capture;
    logic         sample_hit;

    assign accept  = (state == march_idle) && ray.req && !ray.ack;
    assign capture = (state == march_request) && voxel_ack;

    // Sample at floor(position) along x
    assign voxel_addr = {voxel_coord_t'(pos >> FRAC_BITS), map_y, map_z};

    assign sample_hit = (hit.voxel != '0) &&
                        (hit.voxel[ALPHA_LSB +: 8] > 8'(ALPHA_THRESHOLD));

    // ----------------------------------------------------------
    // Handshakes and march control
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= march_idle;
            ray.ack   <= 1'b0;
            voxel_req <= 1'b0;
            hit.req   <= 1'b0;
            hit.hit   <= 1'b0;
        end else begin
            if (ray.ack && !ray.req) begin
                ray.ack <= 1'b0;
            end
            case (state)
                march_idle: begin
                    if (accept) begin
                        ray.ack   <= 1'b1;
                        voxel_req <= 1'b1;
                        state     <= march_request;
                    end
                end
                march_request: begin
                    if (voxel_ack) begin
                        voxel_req <= 1'b0;
                        state     <= march_release;
                    end
                end
                march_release: begin
                    if (!voxel_ack) begin
                        state <= march_test;
                    end
                end
                march_test: begin
                    if (sample_hit) begin
                        hit.hit <= 1'b1;
                        state   <= march_report;
                    end else if (hit.steps == step_count_t'(MAX_STEPS)) begin
                        hit.hit <= 1'b0;
                        state   <= march_report;
                    end else begin
                        voxel_req <= 1'b1;
                        state     <= march_request;
                    end
                end
                march_report: begin
                    if (!hit.req && !hit.ack) begin
                        hit.req <= 1'b1;
                    end else if (hit.req && hit.ack) begin
                        hit.req <= 1'b0;
                        state   <= march_idle;
                    end
                end
                default: state <= march_idle;
            endcase
        end
    end

    // Ray payload, last sample is kept for the shader
    always_ff @(posedge clk) begin
        if (accept) begin
            hit.pixel_x <= ray.pixel_x;
            hit.pixel_y <= ray.pixel_y;
            map_y       <= ray.map_y;
            map_z       <= ray.map_z;
            pos         <= start_pos;
            hit.steps   <= '0;
        end
        if (capture) begin
            hit.voxel   <= voxel_data;
            hit.voxel_x <= voxel_addr[17:12];
            hit.voxel_y <= voxel_addr[11:6];
            hit.voxel_z <= voxel_addr[5:0];
            pos         <= pos - half_step;
            hit.steps   <= hit.steps + 1'b1;
        end
    end

endmodule

/* design/pixel_shader.sv */
`timescale 1ns/1ps

module pixel_shader (
    input  logic                        clk,
    input  logic                        rst_n,
    hit_if.receiver                     hit,
    pixel_if.sender                     pix,
    input  logic                        sel_active,
    input  raycaster_pkg::voxel_coord_t sel_voxel_x,
    input  raycaster_pkg::voxel_coord_t sel_voxel_y,
    input  raycaster_pkg::voxel_coord_t sel_voxel_z
);
    import raycaster_pkg::*;

    // Index 2 is R, 1 is G, 0 is B
    channel_t [2:0] color;
    channel_t [2:0] lit;
    channel_t [2:0] shaded;
    channel_t [2:0] sky;
    channel_t       light;
    channel_t       emissive;
    channel_t       reflection;
    channel_t       refraction;
    channel_t       emission;
    logic [3:0]     mat_type;
    logic           selected;
    logic           loaded;
    logic           accept;
    pixel_word_t    word0_next;
    pixel_word_t    word1_next;

    function automatic channel_t sat_add(channel_t c, logic [8:0] inc);
        logic [9:0] sum;
        sum = 10'(c) + 10'(inc);
        return (sum > 10'd255) ? 8'd255 : sum[7:0];
    endfunction

    assign color    = hit.voxel[COLOR_LSB +: 24];
    assign light    = hit.voxel[LIGHT_LSB +: 8];
    assign emissive = hit.voxel[EMISSIVE_LSB +: 8];
    assign mat_type = hit.voxel[MAT_LSB +: 4];
    assign selected = sel_active && (hit.voxel_x == sel_voxel_x) &&
                      (hit.voxel_y == sel_voxel_y) && (hit.voxel_z == sel_voxel_z);

    // ----------------------------------------------------------
    // Color: light, emission glow, then selection highlight
    // ----------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            lit[i] = channel_t'((16'(color[i]) * 16'(light)) >> 8);
        end
        // Keep unlit voxels visible
        if (lit == '0) begin
            lit = color;
        end
        for (int i = 0; i < 3; i++) begin
            shaded[i] = lit[i];
            if (emissive != '0) begin
                shaded[i] = sat_add(lit[i], 9'((16'(emissive) * 16'(lit[i])) >> 8));
            end
            if (selected) begin
                shaded[i] = sat_add(shaded[i], 9'(SEL_BOOST[i*8 +: 8]));
            end
        end
    end

    // Material fields
    always_comb begin
        case (mat_type)
            MAT_MIRROR: reflection = 8'd255;
            MAT_WATER:  reflection = 8'd200;
            default:    reflection = {hit.voxel[PROPS_LSB + 5 +: 3], 5'd0};
        endcase
        case (mat_type)
            MAT_WATER: refraction = 8'd128;
            MAT_GLASS: refraction = 8'd85;
            default:   refraction = 8'd0;
        endcase
        emission = (mat_type == MAT_EMISSIVE) ? emissive : 8'd0;
    end

    // Sky gradient down the screen
    assign sky[2] = 8'd10 + {3'd0, hit.pixel_y[7:3]};
    assign sky[1] = 8'd40 + {3'd0, hit.pixel_y[7:3]};
    assign sky[0] = 8'd90 + {2'd0, hit.pixel_y[7:2]};

    assign word0_next = hit.hit ? {reflection, refraction, hit.steps, emission}
                                : {8'd0, 8'd0, 8'd255, 8'd0};
    assign word1_next = hit.hit ? {shaded, mat_type, 4'd0} : {sky, SKY_MATERIAL_ID};
    assign pix.word2  = UP_NORMAL_WORD;

    assign accept = hit.req && !hit.ack && !loaded;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit.ack <= 1'b0;
            loaded  <= 1'b0;
            pix.req <= 1'b0;
        end else begin
            if (hit.ack && !hit.req) begin
                hit.ack <= 1'b0;
            end
            if (accept) begin
                hit.ack <= 1'b1;
                loaded  <= 1'b1;
            end
            // Offer the registered result one cycle later
            if (loaded && !pix.req && !pix.ack) begin
                pix.req <= 1'b1;
            end
            if (pix.req && pix.ack) begin
                pix.req <= 1'b0;
                loaded  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pix.pixel_x <= hit.pixel_x;
            pix.pixel_y <= hit.pixel_y;
            pix.word0   <= word0_next;
            pix.word1   <= word1_next;
        end
    end

endmodule

/* design/pixel_writer.sv */
`timescale 1ns/1ps

module pixel_writer #(
    parameter int screen_width  = 480,
    parameter int screen_height = 360
) (
    input  logic                       clk,
    input  logic                       rst_n,
    pixel_if.receiver                  pix,
    output logic                       pixel_req,
    output raycaster_pkg::pixel_addr_t pixel_addr,
    output raycaster_pkg::pixel_word_t pixel_word0,
    output raycaster_pkg::pixel_word_t pixel_word1,
    output raycaster_pkg::pixel_word_t pixel_word2,
    input  logic                       pixel_ack,
    output logic                       frame_done,
    output logic                       done
);
    import raycaster_pkg::*;

    localparam pixel_addr_t last_addr = pixel_addr_t'(screen_width * screen_height - 1);

    logic accept;
    logic last_wait;

    // Take a pixel only when the output side is fully idle
    assign accept = pix.req && !pix.ack && !pixel_req && !pixel_ack;

    // Last pixel sent, frame ends once the sink drops ack
    assign frame_done = last_wait && !pixel_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix.ack   <= 1'b0;
            pixel_req <= 1'b0;
            last_wait <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= frame_done;
            if (pix.ack && !pix.req) begin
                pix.ack <= 1'b0;
            end
            if (accept) begin
                pix.ack   <= 1'b1;
                pixel_req <= 1'b1;
            end
            if (pixel_req && pixel_ack) begin
                pixel_req <= 1'b0;
                if (pixel_addr == last_addr) begin
                    last_wait <= 1'b1;
                end
            end
            if (frame_done) begin
                last_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pixel_addr  <= pixel_addr_t'(pix.pixel_y) * pixel_addr_t'(screen_width) +
                           pixel_addr_t'(pix.pixel_x);
            pixel_word0 <= pix.word0;
            pixel_word1 <= pix.word1;
            pixel_word2 <= pix.word2;
        end
    end

endmodule

/* design/voxel_raycaster.sv */
`timescale 1ns/1ps

module voxel_raycaster #(
    parameter int screen_width  = 480,
    parameter int screen_height = 360
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,

    // Selection highlight
    input  logic                        sel_active,
    input  raycaster_pkg::voxel_coord_t sel_voxel_x,
    input  raycaster_pkg::voxel_coord_t sel_voxel_y,
    input  raycaster_pkg::voxel_coord_t sel_voxel_z,

    // Voxel memory
    output logic                        voxel_req,
    output raycaster_pkg::voxel_addr_t  voxel_addr,
    input  logic                        voxel_ack,
    input  raycaster_pkg::voxel_word_t  voxel_data,

    // Pixel output
    output logic                        pixel_req,
    output raycaster_pkg::pixel_addr_t  pixel_addr,
    output raycaster_pkg::pixel_word_t  pixel_word0,
    output raycaster_pkg::pixel_word_t  pixel_word1,
    output raycaster_pkg::pixel_word_t  pixel_word2,
    input  logic                        pixel_ack,

    output logic                        busy,
    output logic                        done
);

    ray_if   ray_bus ();
    hit_if   hit_bus ();
    pixel_if pix_bus ();

    logic frame_done;

    // ----------------------------------------------------------
    // Scanner, marcher, shader, writer
    // ----------------------------------------------------------
    pixel_scanner #(
        .screen_width  (screen_width),
        .screen_height (screen_height)
    ) pixel_scanner_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .frame_done (frame_done),
        .busy       (busy),
        .ray        (ray_bus.sender)
    );

    ray_marcher ray_marcher_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ray        (ray_bus.receiver),
        .hit        (hit_bus.sender),
        .voxel_req  (voxel_req),
        .voxel_addr (voxel_addr),
        .voxel_ack  (voxel_ack),
        .voxel_data (voxel_data)
    );

    pixel_shader pixel_shader_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .hit         (hit_bus.receiver),
        .pix         (pix_bus.sender),
        .sel_active  (sel_active),
        .sel_voxel_x (sel_voxel_x),
        .sel_voxel_y (sel_voxel_y),
        .sel_voxel_z (sel_voxel_z)
    );

    pixel_writer #(
        .screen_width  (screen_width),
        .screen_height (screen_height)
    ) pixel_writer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix         (pix_bus.receiver),
        .pixel_req   (pixel_req),
        .pixel_addr  (pixel_addr),
        .pixel_word0 (pixel_word0),
        .pixel_word1 (pixel_word1),
        .pixel_word2 (pixel_word2),
        .pixel_ack   (pixel_ack),
        .frame_done  (frame_done),
        .done        (done)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* testbench/voxel_raycaster_tb.sv */
`timescale 1ns/1ps

module voxel_raycaster_tb;
    import raycaster_pkg::*;

    localparam int scr_w        = 8;
    localparam int scr_h        = 6;
    localparam int frame_pixels = scr_w * scr_h;
    localparam int frame_cycles = frame_pixels * 128 * 10;

    logic         clk;
    logic         rst_n;
    logic         start;
    logic         sel_active;
    voxel_coord_t sel_voxel_x;
    voxel_coord_t sel_voxel_y;
    voxel_coord_t sel_voxel_z;
    logic         voxel_req;
    voxel_addr_t  voxel_addr;
    logic         voxel_ack;
    voxel_word_t  voxel_data;
    logic         pixel_req;
    pixel_addr_t  pixel_addr;
    pixel_word_t  pixel_word0;
    pixel_word_t  pixel_word1;
    pixel_word_t  pixel_word2;
    logic         pixel_ack;
    logic         busy;
    logic         done;

    int mismatch_count;
    int other_count;
    int pixel_total;
    int frames_seen;
    int sky_seen;
    int hit_seen;
    int boost_seen;
    logic done_prev;
    logic [127:0] got_q[$];
    event pixel_seen;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    voxel_raycaster #(
        .screen_width  (scr_w),
        .screen_height (scr_h)
    ) voxel_raycaster_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .sel_active  (sel_active),
        .sel_voxel_x (sel_voxel_x),
        .sel_voxel_y (sel_voxel_y),
        .sel_voxel_z (sel_voxel_z),
        .voxel_req   (voxel_req),
        .voxel_addr  (voxel_addr),
        .voxel_ack   (voxel_ack),
        .voxel_data  (voxel_data),
        .pixel_req   (pixel_req),
        .pixel_addr  (pixel_addr),
        .pixel_word0 (pixel_word0),
        .pixel_word1 (pixel_word1),
        .pixel_word2 (pixel_word2),
        .pixel_ack   (pixel_ack),
        .busy        (busy),
        .done        (done)
    );

    // ----------------------------------------------------------
    // Scene: solid block at x 20..40, empty and low-alpha columns
    // ----------------------------------------------------------
    function automatic logic [63:0] scene_voxel(logic [17:0] addr);
        int x;
        int y;
        int z;
        logic [3:0] mat;
        logic [7:0] alpha;
        logic [7:0] light;
        logic [7:0] emis;
        x = addr[17:12];
        y = addr[11:6];
        z = addr[5:0];
        if (x < 20 || x > 40 || z == 0) begin
            return 64'd0;
        end
        mat   = 4'((y / 12 + z / 9) % 6);
        alpha = (z == 63) ? 8'd4 : 8'd200;
        // Column z 18 is unlit
        light = (z == 18) ? 8'd0 : 8'(96 + y * 2);
        emis  = (mat == 4'd1 || z == 45) ? 8'(150 + y) : 8'd0;
        return {8'(x * 5 + y * 3 + z), emis, alpha, light,
                8'(z * 4 + x), 8'(y * 4 + 7), 8'(255 - x * 3), mat, 4'h0};
    endfunction

    function automatic int clamp_byte(int v);
        return (v > 255) ? 255 : v;
    endfunction

    // Expected {word0, word1, word2} for one screen pixel
    function automatic logic [95:0] expected_pixel(int px, int py, logic sel_on,
                                                   int sx, int sy, int sz);
        int my;
        int mz;
        int hx;
        int steps;
        int c[3];
        int l[3];
        int boost[3];
        int refl;
        int refr;
        int emis;
        int light;
        logic found;
        logic [63:0] v;
        logic [63:0] hv;
        logic [3:0] mat;
        logic [7:0] yb;
        logic [31:0] w0;
        logic [31:0] w1;
        my = py * 63 / (scr_h - 1);
        mz = px * 63 / (scr_w - 1);
        found = 1'b0;
        hx = 0;
        steps = 0;
        hv = '0;
        boost = '{96, 16, 96};
        // Sample k sits at 63 - k/2, floored
        for (int k = 0; k < 128; k++) begin
            if (!found) begin
                v = scene_voxel({6'(63 - (k + 1) / 2), 6'(my), 6'(mz)});
                if (v != 64'd0 && v[47:40] > 8'd10) begin
                    found = 1'b1;
                    hx = 63 - (k + 1) / 2;
                    steps = k + 1;
                    hv = v;
                end
            end
        end
        if (!found) begin
            yb = 8'(py);
            w0 = 32'h0000FF00;
            w1 = {8'(10 + yb / 8), 8'(40 + yb / 8), 8'(90 + yb / 4), 8'hFF};
        end else begin
            mat = hv[7:4];
            light = hv[39:32];
            emis = hv[55:48];
            c[0] = hv[31:24];
            c[1] = hv[23:16];
            c[2] = hv[15:8];
            for (int i = 0; i < 3; i++) l[i] = c[i] * light / 256;
            if (l[0] == 0 && l[1] == 0 && l[2] == 0) begin
                l = c;
            end
            for (int i = 0; i < 3; i++) begin
                if (emis != 0) l[i] = clamp_byte(l[i] + emis * l[i] / 256);
                if (sel_on && hx == sx && my == sy && mz == sz) begin
                    l[i] = clamp_byte(l[i] + boost[i]);
                end
            end
            refl = (mat == 4'd3) ? 255 : (mat == 4'd5) ? 200 : hv[63:61] * 32;
            refr = (mat == 4'd5) ? 128 : (mat == 4'd2) ? 85 : 0;
            w0 = {8'(refl), 8'(refr), 8'(steps), (mat == 4'd1) ? 8'(emis) : 8'd0};
            w1 = {8'(l[0]), 8'(l[1]), 8'(l[2]), 8'(mat * 16)};
        end
        return {w0, w1, 32'h00007F00};
    endfunction

    // ----------------------------------------------------------
    // Voxel memory, acks after 0..3 cycles
    // ----------------------------------------------------------
    initial begin
        voxel_ack  = 1'b0;
        voxel_data = '0;
        forever begin
            @(posedge clk);
            if (voxel_req && !voxel_ack) begin
                repeat ($urandom % 4) @(posedge clk);
                voxel_data <= scene_voxel(voxel_addr);
                voxel_ack  <= 1'b1;
                do @(posedge clk); while (voxel_req);
                voxel_ack <= 1'b0;
            end
        end
    end

    // Pixel sink, also checks that held data does not move
    initial begin
        logic [127:0] held;
        pixel_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (pixel_req && !pixel_ack) begin
                repeat ($urandom % 4) @(posedge clk);
                held = {pixel_addr, pixel_word0, pixel_word1, pixel_word2};
                got_q.push_back(held);
                -> pixel_seen;
                pixel_ack <= 1'b1;
                do begin
                    @(posedge clk);
                    if (pixel_req) begin
                        assert ({pixel_addr, pixel_word0, pixel_word1, pixel_word2} == held)
                        else begin
                            other_count++;
                            $display("%0t: pixel data changed while pixel_req was high",
                                     $time);
                        end
                    end
                end while (pixel_req);
                pixel_ack <= 1'b0;
            end
        end
    end

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        assert (got == exp)
        else begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // ----------------------------------------------------------
    // Compare each received pixel with the reference
    // ----------------------------------------------------------
    initial begin
        logic [127:0] got;
        logic [95:0]  exp;
        logic [95:0]  plain;
        int           idx;
        forever begin
            @(pixel_seen);
            while (got_q.size() > 0) begin
                got = got_q.pop_front();
                idx = pixel_total % frame_pixels;
                exp = expected_pixel(idx % scr_w, idx / scr_w, sel_active,
                                     sel_voxel_x, sel_voxel_y, sel_voxel_z);
                plain = expected_pixel(idx % scr_w, idx / scr_w, 1'b0, 0, 0, 0);
                check_word("pixel_addr", got[127:96], 32'(idx));
                check_word("pixel_word0", got[95:64], exp[95:64]);
                check_word("pixel_word1", got[63:32], exp[63:32]);
                check_word("pixel_word2", got[31:0], exp[31:0]);
                if (got[39:32] == 8'hFF) sky_seen++;
                else hit_seen++;
                if (got[95:0] != plain) boost_seen++;
                pixel_total++;
            end
        end
    end

    // Frame end: one-cycle done, busy falls with it
    always @(posedge clk) begin
        if (rst_n && done) begin
            frames_seen++;
            assert (!busy && !done_prev && pixel_total == frames_seen * frame_pixels)
            else begin
                other_count++;
                $display("%0t: done pulse wrong (busy %0b, pixels %0d)",
                         $time, busy, pixel_total);
            end
        end
        done_prev <= done;
    end

    task automatic run_frame(int target);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        assert (busy)
        else begin
            other_count++;
            $display("%0t: busy did not rise after start", $time);
        end
        // Extra start pulses while busy must be ignored
        repeat (2) begin
            repeat (20 + $urandom % 10) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        // One more while the scanner is parked and the last pixel drains
        while (!(pixel_req && pixel_addr == pixel_addr_t'(frame_pixels - 1))) begin
            @(posedge clk);
        end
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (frames_seen < target) @(posedge clk);
        repeat (30) @(posedge clk);
        assert (!busy && !pixel_req && pixel_total == target * frame_pixels)
        else begin
            other_count++;
            $display("%0t: core not idle after frame %0d", $time, target);
        end
    endtask

    // Watchdog
    initial begin
        #((2 * frame_cycles + 2000) * 10);
        $display("%0t: timeout, frame did not finish", $time);
        $display("TEST FAILED");
        $finish;
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        int seed_val;
        seed_val = $urandom(89);
        mismatch_count = 0;
        other_count = 0;
        pixel_total = 0;
        frames_seen = 0;
        sky_seen = 0;
        hit_seen = 0;
        boost_seen = 0;
        done_prev = 1'b0;
        start = 1'b0;
        sel_active = 1'b0;
        sel_voxel_x = '0;
        sel_voxel_y = '0;
        sel_voxel_z = '0;
        @(posedge rst_n);
        assert (!busy && !done && !voxel_req && !pixel_req)
        else begin
            other_count++;
            $display("%0t: outputs not idle after reset", $time);
        end
        run_frame(1);
        // Pixel (2, 1) sees voxel (40, 12, 18) first
        @(posedge clk);
        sel_active  <= 1'b1;
        sel_voxel_x <= 6'd40;
        sel_voxel_y <= 6'd12;
        sel_voxel_z <= 6'd18;
        run_frame(2);
        assert (sky_seen > 0 && hit_seen > 0 && boost_seen == 1)
        else begin
            other_count++;
            $display("%0t: scene coverage wrong (sky %0d, hit %0d, boosted %0d)",
                     $time, sky_seen, hit_seen, boost_seen);
        end
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* voxel_raycaster.f */
design/raycaster_pkg.sv
design/raycaster_ifs.sv
design/pixel_scanner.sv
design/ray_marcher.sv
design/pixel_shader.sv
design/pixel_writer.sv
design/voxel_raycaster.sv
testbench/tb_clock_gen.sv
testbench/voxel_raycaster_tb.sv

/* Makefile */
TB_TOP = voxel_raycaster_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module voxel_raycaster \
		design/raycaster_pkg.sv design/raycaster_ifs.sv design/pixel_scanner.sv \
		design/ray_marcher.sv design/pixel_shader.sv design/pixel_writer.sv \
		design/voxel_raycaster.sv

sim:
	verilator --binary --timing --assert -f voxel_raycaster.f \
		--top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
